// File: test/exu_stim.txt
# kind op src1 src2 br_op pc rs1 imm ren wen wdata wsize rsize rext brk rd, then expected
# reg_wen reg_wdata jmp_pc halted, all hex. X draws random operands, M tracks memory, R resets.
V 1 5 7 4 100 0 fffffff0 0 0 0 0 0 0 0 1 1 fffffffe f0 0
V 5 1 24 0 100 0 0 0 0 0 0 0 0 0 1 1 10 104 0
V 7 80000000 4 0 100 0 0 0 0 0 0 0 0 0 1 1 f8000000 104 0
V 8 ffffffff 1 5 100 0 20 0 0 0 0 0 0 0 1 1 1 120 0
V 9 ffffffff 1 7 100 0 20 0 0 0 0 0 0 0 1 1 0 104 0
V a 0 12345000 1 100 0 40 0 0 0 0 0 0 0 1 1 12345000 140 0
X 0 0 0 0 100 0 0 0 0 0 0 0 0 0 0 0 0 104 0
X 2 0 0 0 100 0 0 0 0 0 0 0 0 0 2 1 0 104 0
X 3 0 0 0 100 0 0 0 0 0 0 0 0 0 2 1 0 104 0
X 4 0 0 0 100 0 0 0 0 0 0 0 0 0 2 1 0 104 0
X 6 0 0 0 100 0 0 0 0 0 0 0 0 0 2 1 0 104 0
V 0 1000 1 2 100 1001 10 0 0 0 0 0 0 0 3 1 1001 1010 0
V 1 7 7 3 200 0 20 0 0 0 0 0 0 0 3 1 0 220 0
V 8 1 ffffffff 6 200 0 20 0 0 0 0 0 0 0 3 1 0 220 0
V 9 1 2 8 200 0 20 0 0 0 0 0 0 0 3 1 1 204 0
M 0 40 0 0 100 0 0 0 1 11223344 2 0 0 0 0 0 40 104 0
M 0 40 1 0 100 0 0 0 1 123456a5 0 0 0 0 0 0 41 104 0
M 0 40 2 0 100 0 0 0 1 7f 0 0 0 0 0 0 42 104 0
M 0 40 3 0 100 0 0 0 1 ffffff80 0 0 0 0 0 0 43 104 0
M 0 40 0 0 100 0 0 0 1 5c 0 0 0 0 0 0 40 104 0
M 0 44 0 0 100 0 0 0 1 1234f00d 1 0 0 0 0 0 44 104 0
M 0 44 2 0 100 0 0 0 1 7acd 1 0 0 0 0 0 46 104 0
M 0 40 1 0 100 0 0 1 0 0 0 0 1 0 5 1 0 104 0
M 0 40 2 0 100 0 0 1 0 0 0 0 2 0 5 1 0 104 0
M 0 40 3 0 100 0 0 1 0 0 0 0 1 0 5 1 0 104 0
M 0 40 0 0 100 0 0 1 0 0 0 0 0 0 5 1 0 104 0
M 0 44 0 0 100 0 0 1 0 0 0 1 1 0 5 1 0 104 0
M 0 44 2 0 100 0 0 1 0 0 0 1 2 0 5 1 0 104 0
M 0 44 0 0 100 0 0 1 0 0 0 2 0 0 5 1 0 104 0
V 0 3 4 0 100 0 0 0 0 0 0 0 0 1 6 1 7 104 0
M 0 40 0 0 100 0 0 0 1 deadbeef 2 0 0 0 6 0 40 104 1
R
M 0 40 0 0 100 0 0 1 0 0 0 2 0 0 7 1 0 104 0

// File: list.f
hw/exu_pkg.sv
hw/mem_pkg.sv
hw/mem_if.sv
hw/alu.sv
hw/bru.sv
hw/lsu.sv
hw/data_mem.sv
hw/exu.sv
test/tb_exu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_exu
FILELIST   := list.f
COMMON     := --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary -j 0 $(COMMON)
LINT_FLAGS := --lint-only $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_exu.sv
`timescale 1ns/1ps

module tb_exu
    import exu_pkg::*, mem_pkg::*;
();

    localparam string STIM_FILE = "test/exu_stim.txt";

    logic        clk;
    logic        rst_n;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    alu_op_e     alu_op;
    branch_op_e  br_op;
    logic [31:0] br_pc;
    logic [31:0] br_rs1;
    logic [31:0] br_imm;
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] mem_wdata;
    mem_size_e   mem_wsize;
    mem_size_e   mem_rsize;
    load_ext_e   mem_rext;
    logic        break_req;
    logic [4:0]  rd;
    logic        reg_wen;
    logic [4:0]  reg_waddr;
    logic [31:0] reg_wdata;
    logic [31:0] jmp_pc;
    logic        halted;

    logic [7:0]  mem_model [1024]; // Byte image of everything stored so far.
    string       vectors [$];
    int          errors;
    int          checks;
    int          budget_cycles;
    integer      seed;

    exu #(.MEM_ADDR_BITS(8)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * 100);
        $display("Watchdog expired, the test did not finish within %0d cycles", budget_cycles);
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
            ALU_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_PASS: return b;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] load_model(input logic [9:0] addr, input mem_size_e size,
                                               input load_ext_e ext);
        logic [9:0]  base;
        logic [15:0] half;
        logic [7:0]  byte_val;
        base = {addr[9:2], 2'b00};
        half = {mem_model[addr + 10'd1], mem_model[addr]};
        byte_val = mem_model[addr];
        if (ext == EXT_NONE || size == MEM_WORD) begin
            return {mem_model[base + 10'd3], mem_model[base + 10'd2],
                    mem_model[base + 10'd1], mem_model[base]};
        end
        if (size == MEM_HALF) begin
            return (ext == EXT_SIGN) ? {{16{half[15]}}, half} : {16'h0, half};
        end
        return (ext == EXT_SIGN) ? {{24{byte_val[7]}}, byte_val} : {24'h0, byte_val};
    endfunction

    task automatic store_model(input logic [9:0] addr, input mem_size_e size,
                               input logic [31:0] data);
        int n;
        n = (size == MEM_BYTE) ? 1 : (size == MEM_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            mem_model[addr + 10'(i)] = data[i*8 +: 8];
        end
    endtask

    task automatic idle_inputs();
        alu_src1  = 32'h0;
        alu_src2  = 32'h0;
        alu_op    = ALU_ADD;
        br_op     = BR_NONE;
        br_pc     = 32'h0;
        br_rs1    = 32'h0;
        br_imm    = 32'h0;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_wdata = 32'h0;
        mem_wsize = MEM_BYTE;
        mem_rsize = MEM_BYTE;
        mem_rext  = EXT_NONE;
        break_req = 1'b0;
        rd        = 5'd0;
    endtask

    task automatic reset_dut();
        idle_inputs();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
    endtask

    task automatic drive_vector(input logic [31:0] v [19]);
        alu_op    = alu_op_e'(v[0][3:0]);
        alu_src1  = v[1];
        alu_src2  = v[2];
        br_op     = branch_op_e'(v[3][3:0]);
        br_pc     = v[4];
        br_rs1    = v[5];
        br_imm    = v[6];
        mem_ren   = v[7][0];
        mem_wen   = v[8][0];
        mem_wdata = v[9];
        mem_wsize = mem_size_e'(v[10][1:0]);
        mem_rsize = mem_size_e'(v[11][1:0]);
        mem_rext  = load_ext_e'(v[12][1:0]);
        break_req = v[13][0];
        rd        = v[14][4:0];
    endtask

    task automatic compare_output(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          n_resets;
        string       line;
        byte         kind;
        logic [31:0] f [19];
        logic [31:0] exp_wdata;
        logic [31:0] addr;

        errors   = 0;
        checks   = 0;
        n_resets = 0;
        seed     = 32'h5a5;
        idle_inputs();
        rst_n = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    vectors.push_back(line);
                    if (line.getc(0) == "R") n_resets++;
                end
            end
            $fclose(fd);
        end
        budget_cycles = vectors.size() + 3 * n_resets + 20;
        reset_dut();
        foreach (vectors[i]) begin
            line = vectors[i];
            kind = line.getc(0);
            @(posedge clk);
            #10;
            if (kind == "R") begin
                reset_dut();
                continue;
            end
            n = $sscanf(line.substr(1, line.len() - 1),
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
            if (n != 19) begin
                $display("Vector %0d could not be parsed and was skipped", i);
                errors++;
                continue;
            end
            if (kind == "X") begin
                f[1] = $random(seed);
                f[2] = $random(seed);
            end
            drive_vector(f);
            #80; // Sample 10 ns before the next rising edge.
            exp_wdata = f[16];
            addr = f[1] + f[2];
            if (kind == "X") exp_wdata = alu_model(alu_op_e'(f[0][3:0]), f[1], f[2]);
            if (kind == "M" && f[7][0]) begin
                exp_wdata = load_model(addr[9:0], mem_size_e'(f[11][1:0]),
                                       load_ext_e'(f[12][1:0]));
            end
            compare_output("reg_wen", {31'b0, reg_wen}, f[15]);
            compare_output("reg_waddr", {27'b0, reg_waddr}, {27'b0, f[14][4:0]});
            compare_output("reg_wdata", reg_wdata, exp_wdata);
            compare_output("jmp_pc", jmp_pc, f[17]);
            compare_output("halted", {31'b0, halted}, f[18]);
            // A store lands at the coming edge unless the core is halted.
            if (kind == "M" && f[8][0] && !f[18][0]) begin
                store_model(addr[9:0], mem_size_e'(f[10][1:0]), f[9]);
            end
        end
        $display("Ran %0d vectors, %0d checks, %0d errors", vectors.size(), checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: hw/exu.sv
`timescale 1ns/1ps

module exu
    import exu_pkg::*, mem_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [XLEN-1:0]          alu_src1,
    input  logic [XLEN-1:0]          alu_src2,
    input  alu_op_e                  alu_op,
    input  branch_op_e               br_op,
    input  logic [XLEN-1:0]          br_pc,
    input  logic [XLEN-1:0]          br_rs1,
    input  logic [XLEN-1:0]          br_imm,
    input  logic                     mem_ren,
    input  logic                     mem_wen,
    input  logic [XLEN-1:0]          mem_wdata,
    input  mem_size_e                mem_wsize,
    input  mem_size_e                mem_rsize,
    input  load_ext_e                mem_rext,
    input  logic                     break_req,
    input  logic [REG_ADDR_BITS-1:0] rd,
    output logic                     reg_wen,
    output logic [REG_ADDR_BITS-1:0] reg_waddr,
    output logic [XLEN-1:0]          reg_wdata,
    output logic [XLEN-1:0]          jmp_pc,
    output logic                     halted
);

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic            alu_zero;
    logic            alu_less;

    mem_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem_bus ();

    // Once a break is seen the core stops committing until reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (break_req) begin
            halted <= 1'b1;
        end
    end

    alu u_alu (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero),
        .less   (alu_less)
    );

    bru u_bru (
        .op     (br_op),
        .pc     (br_pc),
        .rs1    (br_rs1),
        .imm    (br_imm),
        .zero   (alu_zero),
        .less   (alu_less),
        .jmp_pc (jmp_pc)
    );

    lsu #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_lsu (
        .ren       (mem_ren),
        .wen       (mem_wen),
        .addr      (alu_result), // Effective address comes from the ALU.
        .wdata     (mem_wdata),
        .wsize     (mem_wsize),
        .rsize     (mem_rsize),
        .rext      (mem_rext),
        .block     (halted),
        .mem       (mem_bus.lsu_mp),
        .load_data (load_data)
    );

    data_mem #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus.mem_mp)
    );

    assign reg_wen   = (rd != '0) && !halted;
    assign reg_waddr = rd;
    assign reg_wdata = mem_ren ? load_data : alu_result;

    // The lsu must not pass a store on to the memory while halted.
    assert property (@(posedge clk) disable iff (!rst_n) halted |-> !mem_bus.wen)
        else $error("memory write while halted");

endmodule

// File: hw/data_mem.sv
`timescale 1ns/1ps

module data_mem
    import mem_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    mem_if.mem_mp mem
);

    logic [31:0] ram [2**MEM_ADDR_BITS];

    // Byte lanes are written independently under the mask.
    always_ff @(posedge clk) begin
        if (rst_n && mem.wen) begin
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (mem.wmask[i]) begin
                    ram[mem.addr][i*8 +: 8] <= mem.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign mem.rdata = ram[mem.addr]; // Asynchronous read.

    // A write with an empty mask means the lsu built a bad mask.
    assert property (@(posedge clk) disable iff (!rst_n) mem.wen |-> mem.wmask != '0)
        else $error("data_mem write with empty byte mask");

endmodule

// File: hw/lsu.sv
`timescale 1ns/1ps

module lsu
    import mem_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  mem_size_e   wsize,
    input  mem_size_e   rsize,
    input  load_ext_e   rext,
    input  logic        block,
    mem_if.lsu_mp       mem,
    output logic [31:0] load_data
);

    logic [1:0]  offset;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic [31:0] ext_data;

    function automatic logic misaligned(input mem_size_e size, input logic [1:0] off);
        return (size == MEM_HALF && off[0]) || (size == MEM_WORD && off != 2'b00);
    endfunction

    assign offset = addr[1:0];

    always_comb begin
        case (wsize)
            MEM_BYTE: mem.wmask = 4'b0001 << offset;
            MEM_HALF: mem.wmask = 4'b0011 << offset;
            default:  mem.wmask = 4'b1111;
        endcase
    end

    // Replicate the store data so every enabled lane sees the right bytes.
    always_comb begin
        case (wsize)
            MEM_BYTE: mem.wdata = {4{wdata[7:0]}};
            MEM_HALF: mem.wdata = {2{wdata[15:0]}};
            default:  mem.wdata = wdata;
        endcase
    end

    assign mem.wen  = wen & ~block;
    assign mem.addr = addr[MEM_ADDR_BITS+1:2];

    assign rd_byte = mem.rdata[{offset, 3'b000} +: 8];
    assign rd_half = offset[1] ? mem.rdata[31:16] : mem.rdata[15:0];

    always_comb begin
        ext_data = mem.rdata;
        if (rext == EXT_SIGN && rsize == MEM_BYTE) ext_data = {{24{rd_byte[7]}}, rd_byte};
        if (rext == EXT_SIGN && rsize == MEM_HALF) ext_data = {{16{rd_half[15]}}, rd_half};
        if (rext == EXT_ZERO && rsize == MEM_BYTE) ext_data = {24'h0, rd_byte};
        if (rext == EXT_ZERO && rsize == MEM_HALF) ext_data = {16'h0, rd_half};
    end

    assign load_data = ren ? ext_data : 32'h0;

    always_comb begin
        if (wen) assert final (!misaligned(wsize, offset)) else $error("misaligned store");
        if (ren) assert final (!misaligned(rsize, offset)) else $error("misaligned load");
    end

endmodule

// File: hw/bru.sv
`timescale 1ns/1ps

module bru
    import exu_pkg::*;
(
    input  branch_op_e      op,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] imm,
    input  logic            zero,
    input  logic            less,
    output logic [XLEN-1:0] jmp_pc
);

    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] rel_pc;
    logic [XLEN-1:0] ind_pc;
    logic            taken;

    assign seq_pc = pc + 32'd4;
    assign rel_pc = pc + imm;
    assign ind_pc = (rs1 + imm) & ~32'd1; // jalr drops bit 0.

    always_comb begin
        case (op)
            BR_BEQ:           taken = zero;
            BR_BNE:           taken = ~zero;
            BR_BLT, BR_BLTU:  taken = less;
            BR_BGE, BR_BGEU:  taken = ~less;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            BR_JAL:  jmp_pc = rel_pc;
            BR_JALR: jmp_pc = ind_pc;
            default: jmp_pc = taken ? rel_pc : seq_pc;
        endcase
    end

    // Holds only if the decoder supplies an even pc and even offsets.
    always_comb begin
        assert final (jmp_pc[0] !== 1'b1)
            else $error("bru next pc is odd");
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu
    import exu_pkg::*;
(
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output logic            zero,
    output logic            less
);

    logic [4:0] shamt;

    assign shamt = src2[4:0]; // Only the low five bits count for RV32 shifts.

    always_comb begin
        case (op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, src1 < src2};
            ALU_PASS: result = src2;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);
    assign less = result[0]; // Valid only when op is a set-less-than.

endmodule

// File: hw/mem_if.sv
`timescale 1ns/1ps

interface mem_if
    import mem_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 8
) ();

    logic                     wen;
    logic [MEM_ADDR_BITS-1:0] addr;  // Word index, not a byte address.
    logic [31:0]              wdata;
    logic [BYTE_LANES-1:0]    wmask;
    logic [31:0]              rdata; // Combinational in addr.

    modport lsu_mp (
        output wen, addr, wdata, wmask,
        input  rdata
    );

    modport mem_mp (
        input  wen, addr, wdata, wmask,
        output rdata
    );

endinterface

// File: hw/mem_pkg.sv
package mem_pkg;

    parameter int BYTE_LANES    = 4; // One mask bit per byte of a word.
    parameter int MEM_SIZE_BITS = 2;
    parameter int LOAD_EXT_BITS = 2;

    typedef enum logic [MEM_SIZE_BITS-1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // Extension none returns the whole word untouched.
    typedef enum logic [LOAD_EXT_BITS-1:0] {
        EXT_NONE = 2'd0,
        EXT_SIGN = 2'd1,
        EXT_ZERO = 2'd2
    } load_ext_e;

endpackage

// File: hw/exu_pkg.sv
package exu_pkg;

    parameter int XLEN          = 32; // Data path width.
    parameter int REG_ADDR_BITS = 5;
    parameter int ALU_OP_BITS   = 4;
    parameter int BR_OP_BITS    = 4;

    typedef enum logic [ALU_OP_BITS-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_PASS = 4'd10 // Forwards src2, used for lui.
    } alu_op_e;

    typedef enum logic [BR_OP_BITS-1:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } branch_op_e;

endpackage
